//--- hw/cachePkg.sv
package cachePkg;

	// Default widths. The top level passes ADDRESS_WIDTH down and it must match.
	localparam int ADDRESS_WIDTH_DEFAULT = 8;
	localparam int DATA_WIDTH_DEFAULT = 16;

	typedef logic [ADDRESS_WIDTH_DEFAULT-1:0] address_t;
	typedef logic [DATA_WIDTH_DEFAULT-1:0] data_t;

	// MSI line states.
	typedef enum logic [1:0] {
		Invalid,
		Shared,
		Modified
	} lineState_t;

	// Commands seen on the snooped bus.
	typedef enum logic [1:0] {
		BusRd,
		BusRdX,
		BusUpgr,
		BusWb
	} busCommand_t;

	typedef struct packed {
		address_t address;
		data_t dataOut;
		logic readEnabled;
		logic writeEnabled;
	} deviceRequest_t;

	typedef struct packed {
		data_t dataIn;
		logic functionComplete;
	} deviceResponse_t;

	typedef struct packed {
		logic valid;
		busCommand_t command;
		address_t address;
		data_t data;
	} busTransaction_t;

	// Memory side uses the same layout as the device side.
	typedef deviceRequest_t ramRequest_t;
	typedef deviceResponse_t ramResponse_t;

endpackage

//--- hw/BusArbiter.sv
`timescale 1ns/1ps

module BusArbiter #(
	parameter int NUMBER_OF_DEVICES = 2
) (
	input logic clock,
	input logic rstN,
	input logic [NUMBER_OF_DEVICES-1:0] requests,
	output logic [NUMBER_OF_DEVICES-1:0] grant
);
	localparam int POINTER_WIDTH = (NUMBER_OF_DEVICES > 1) ? $clog2(NUMBER_OF_DEVICES) : 1;

	logic [POINTER_WIDTH-1:0] lastGranted, nextGranted;
	logic [NUMBER_OF_DEVICES-1:0] nextGrant;

	// Nearest requester after the last winner takes the bus.
	always_comb begin
		int candidate;
		nextGrant = '0;
		nextGranted = lastGranted;
		for (int offset = NUMBER_OF_DEVICES; offset >= 1; offset--) begin
			candidate = (int'(lastGranted) + offset) % NUMBER_OF_DEVICES;
			if (requests[candidate]) begin
				nextGrant = '0;
				nextGrant[candidate] = 1'b1;
				nextGranted = POINTER_WIDTH'(candidate);
			end
		end
	end

	// Grant is held until the owner drops its request.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			grant <= '0;
			lastGranted <= POINTER_WIDTH'(NUMBER_OF_DEVICES - 1);
		end else if ((grant & requests) == '0) begin
			grant <= nextGrant;
			lastGranted <= nextGranted;
		end
	end

endmodule

//--- hw/Ram.sv
`timescale 1ns/1ps

module Ram #(
	parameter int ADDRESS_WIDTH = 8,
	parameter int RAM_DELAY = 3
) (
	input logic clock,
	input logic rstN,
	input cachePkg::ramRequest_t request,
	output cachePkg::ramResponse_t response
);
	import cachePkg::*;

	localparam int WORDS = 2 ** ADDRESS_WIDTH;
	localparam int COUNT_WIDTH = $clog2(RAM_DELAY + 1);

	data_t memory [WORDS];
	data_t readData;
	logic [WORDS-1:0] written;
	logic [COUNT_WIDTH-1:0] count;
	logic complete, access, lastCycle;

	assign access = (request.readEnabled || request.writeEnabled) && !complete;
	assign lastCycle = access && (count == COUNT_WIDTH'(RAM_DELAY - 1));

	// Words never written read as zero.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			count <= '0;
			complete <= 1'b0;
			written <= '0;
		end else begin
			complete <= lastCycle;
			if (lastCycle)
				count <= '0;
			else if (access)
				count <= count + 1'b1;
			if (lastCycle && request.writeEnabled)
				written[request.address] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (lastCycle && request.writeEnabled)
			memory[request.address] <= request.dataOut;
		if (lastCycle)
			readData <= written[request.address] ? memory[request.address] : '0;
	end

	assign response = '{dataIn: readData, functionComplete: complete};

endmodule

//--- hw/MsiCache.sv
`timescale 1ns/1ps

module MsiCache #(
	parameter int ADDRESS_WIDTH = 8,
	parameter int INDEX_WIDTH = 3
) (
	input logic clock,
	input logic rstN,
	input cachePkg::deviceRequest_t request,
	output cachePkg::deviceResponse_t response,
	output logic busRequest,
	output cachePkg::busTransaction_t ownTransaction,
	input logic granted,
	input logic busDone,
	input cachePkg::data_t busData,
	input cachePkg::busTransaction_t snoop,
	output logic flushNeeded,
	output cachePkg::data_t flushData
);
	import cachePkg::*;

	localparam int TAG_WIDTH = ADDRESS_WIDTH - INDEX_WIDTH;
	localparam int LINES = 2 ** INDEX_WIDTH;

	typedef logic [INDEX_WIDTH-1:0] index_t;
	typedef logic [TAG_WIDTH-1:0] tag_t;
	typedef enum logic [2:0] {
		Idle,
		Lookup,
		WriteBack,
		Fill,
		Upgrade
	} controllerState_t;

	controllerState_t state, nextState;
	deviceRequest_t pending;

	tag_t tagArray [LINES];
	lineState_t stateArray [LINES];
	data_t dataArray [LINES];

	index_t index, snoopIndex;
	tag_t tag, snoopTag;
	lineState_t lineState, snoopState;
	logic tagMatch, hitComplete;
	logic snoopHit, snoopConflict;

	assign index = pending.address[INDEX_WIDTH-1:0];
	assign tag = pending.address[ADDRESS_WIDTH-1:INDEX_WIDTH];
	assign lineState = stateArray[index];
	assign tagMatch = (tagArray[index] == tag) && (lineState != Invalid);

	// Own transaction also shows up on the bus while granted.
	assign snoopIndex = snoop.address[INDEX_WIDTH-1:0];
	assign snoopTag = snoop.address[ADDRESS_WIDTH-1:INDEX_WIDTH];
	assign snoopState = stateArray[snoopIndex];
	assign snoopHit = snoop.valid && !granted && (snoopState != Invalid) &&
		(tagArray[snoopIndex] == snoopTag);
	assign snoopConflict = snoop.valid && !granted && (snoopIndex == index);

	assign flushNeeded = snoopHit && (snoopState == Modified) &&
		((snoop.command == BusRd) || (snoop.command == BusRdX));
	assign flushData = dataArray[snoopIndex];

	// Hits stall for one cycle when the same index is being snooped.
	always_comb begin
		hitComplete = 1'b0;
		if (tagMatch && !snoopConflict) begin
			if (pending.readEnabled)
				hitComplete = 1'b1;
			else
				hitComplete = (lineState == Modified);
		end
	end

	assign response.dataIn = dataArray[index];
	assign response.functionComplete = (state == Lookup) && hitComplete;

	always_comb begin
		nextState = state;
		case (state)
			Idle:
				if (request.readEnabled || request.writeEnabled)
					nextState = Lookup;
			Lookup:
				if (hitComplete)
					nextState = Idle;
				else if (snoopConflict)
					nextState = Lookup;
				else if (tagMatch)
					nextState = Upgrade;
				else if (lineState == Modified)
					nextState = WriteBack;
				else
					nextState = Fill;
			// Victim may lose ownership to a snoop while waiting for the bus.
			WriteBack:
				if (busDone || (lineState != Modified))
					nextState = Lookup;
			Fill:
				if (busDone)
					nextState = Lookup;
			Upgrade:
				if (busDone || !(tagMatch && (lineState == Shared)))
					nextState = Lookup;
			default:
				nextState = Idle;
		endcase
	end

	always_comb begin
		busRequest = 1'b0;
		ownTransaction = '0;
		ownTransaction.address = pending.address;
		ownTransaction.data = pending.dataOut;
		case (state)
			WriteBack: begin
				busRequest = (lineState == Modified);
				ownTransaction.command = BusWb;
				ownTransaction.address = {tagArray[index], index};
				ownTransaction.data = dataArray[index];
			end
			Fill: begin
				busRequest = 1'b1;
				ownTransaction.command = pending.writeEnabled ? BusRdX : BusRd;
			end
			Upgrade: begin
				busRequest = tagMatch && (lineState == Shared);
				ownTransaction.command = BusUpgr;
			end
			default:
				busRequest = 1'b0;
		endcase
		ownTransaction.valid = busRequest;
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= Idle;
			for (int i = 0; i < LINES; i++)
				stateArray[i] <= Invalid;
		end else begin
			state <= nextState;
			if (snoopHit) begin
				case (snoop.command)
					BusRd:
						if (snoopState == Modified)
							stateArray[snoopIndex] <= Shared;
					BusRdX, BusUpgr:
						stateArray[snoopIndex] <= Invalid;
				endcase
			end
			if (busDone) begin
				if (state == WriteBack)
					stateArray[index] <= Invalid;
				else if (state == Upgrade)
					stateArray[index] <= Modified;
				else if (state == Fill && pending.writeEnabled)
					stateArray[index] <= Modified;
				else if (state == Fill)
					stateArray[index] <= Shared;
			end
		end
	end

	// Write misses take the new word instead of the fill data.
	always_ff @(posedge clock) begin
		if (state == Idle)
			pending <= request;
		if (busDone && (state == Fill)) begin
			tagArray[index] <= tag;
			dataArray[index] <= pending.writeEnabled ? pending.dataOut : busData;
		end
		if ((state == Lookup) && hitComplete && pending.writeEnabled)
			dataArray[index] <= pending.dataOut;
	end

endmodule

//--- hw/MsiCacheSystem.sv
`timescale 1ns/1ps

module MsiCacheSystem #(
	parameter int NUMBER_OF_DEVICES = 2,
	parameter int ADDRESS_WIDTH = 8,
	parameter int INDEX_WIDTH = 3
) (
	input logic clock,
	input logic rstN,
	input cachePkg::deviceRequest_t deviceRequest [NUMBER_OF_DEVICES],
	output cachePkg::deviceResponse_t deviceResponse [NUMBER_OF_DEVICES],
	output cachePkg::ramRequest_t ramRequest,
	input cachePkg::ramResponse_t ramResponse
);
	import cachePkg::*;

	typedef enum logic [1:0] {
		SeqIdle,
		SeqFlush,
		SeqMemory,
		SeqUpgrade
	} sequencerState_t;

	sequencerState_t state;
	logic [NUMBER_OF_DEVICES-1:0] busRequest, grant, flushNeeded;
	busTransaction_t ownTransaction [NUMBER_OF_DEVICES];
	data_t flushData [NUMBER_OF_DEVICES];
	busTransaction_t grantedTransaction, sharedBus;
	data_t ownerData, flushBuffer;
	logic active, done;

	for (genvar i = 0; i < NUMBER_OF_DEVICES; i++) begin : gCache
		MsiCache #(
			.ADDRESS_WIDTH(ADDRESS_WIDTH),
			.INDEX_WIDTH(INDEX_WIDTH)
		) cache (
			.clock(clock),
			.rstN(rstN),
			.request(deviceRequest[i]),
			.response(deviceResponse[i]),
			.busRequest(busRequest[i]),
			.ownTransaction(ownTransaction[i]),
			.granted(grant[i]),
			.busDone(done && grant[i]),
			.busData(ramResponse.dataIn),
			.snoop(sharedBus),
			.flushNeeded(flushNeeded[i]),
			.flushData(flushData[i])
		);
	end

	BusArbiter #(
		.NUMBER_OF_DEVICES(NUMBER_OF_DEVICES)
	) arbiter (
		.clock(clock),
		.rstN(rstN),
		.requests(busRequest),
		.grant(grant)
	);

	always_comb begin
		grantedTransaction = '0;
		ownerData = '0;
		for (int i = 0; i < NUMBER_OF_DEVICES; i++) begin
			if (grant[i])
				grantedTransaction = ownTransaction[i];
			if (flushNeeded[i])
				ownerData = flushData[i];
		end
	end

	// Transaction is visible to snoopers only in its first cycle.
	assign active = |(grant & busRequest);
	always_comb begin
		sharedBus = grantedTransaction;
		sharedBus.valid = active && (state == SeqIdle);
	end

	assign done = (state == SeqUpgrade) || ((state == SeqMemory) && ramResponse.functionComplete);

	always_comb begin
		ramRequest = '0;
		ramRequest.address = grantedTransaction.address;
		ramRequest.dataOut = grantedTransaction.data;
		if (state == SeqFlush) begin
			ramRequest.dataOut = flushBuffer;
			ramRequest.writeEnabled = 1'b1;
		end else if (state == SeqMemory) begin
			ramRequest.writeEnabled = (grantedTransaction.command == BusWb);
			ramRequest.readEnabled = (grantedTransaction.command != BusWb);
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= SeqIdle;
		end else begin
			case (state)
				SeqIdle:
					if (active && (|flushNeeded))
						state <= SeqFlush;
					else if (active && (grantedTransaction.command == BusUpgr))
						state <= SeqUpgrade;
					else if (active)
						state <= SeqMemory;
				SeqFlush:
					if (ramResponse.functionComplete)
						state <= SeqMemory;
				SeqMemory:
					if (ramResponse.functionComplete)
						state <= SeqIdle;
				default:
					state <= SeqIdle;
			endcase
		end
	end

	// Owner data captured while its state changes.
	always_ff @(posedge clock) begin
		if (state == SeqIdle)
			flushBuffer <= ownerData;
	end

endmodule

//--- hw/MemorySystem.sv
`timescale 1ns/1ps

module MemorySystem #(
	parameter int NUMBER_OF_DEVICES = 2,
	parameter int ADDRESS_WIDTH = cachePkg::ADDRESS_WIDTH_DEFAULT,
	parameter int INDEX_WIDTH = 3,
	parameter int RAM_DELAY = 3
) (
	input logic clock,
	input logic rstN,
	input cachePkg::deviceRequest_t deviceRequest [NUMBER_OF_DEVICES],
	output cachePkg::deviceResponse_t deviceResponse [NUMBER_OF_DEVICES]
);
	import cachePkg::*;

	ramRequest_t ramRequest;
	ramResponse_t ramResponse;

	MsiCacheSystem #(
		.NUMBER_OF_DEVICES(NUMBER_OF_DEVICES),
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.INDEX_WIDTH(INDEX_WIDTH)
	) cacheSystem (
		.clock(clock),
		.rstN(rstN),
		.deviceRequest(deviceRequest),
		.deviceResponse(deviceResponse),
		.ramRequest(ramRequest),
		.ramResponse(ramResponse)
	);

	Ram #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.RAM_DELAY(RAM_DELAY)
	) ram (
		.clock(clock),
		.rstN(rstN),
		.request(ramRequest),
		.response(ramResponse)
	);

endmodule

//--- tests/memorySystem_props.sv
`timescale 1ns/1ps

module memorySystem_props #(
	parameter int NUMBER_OF_DEVICES = 2,
	parameter int ADDRESS_WIDTH = 8,
	parameter int INDEX_WIDTH = 3
) (
	input logic clock,
	input logic rstN,
	input cachePkg::deviceRequest_t deviceRequest [NUMBER_OF_DEVICES],
	input cachePkg::deviceResponse_t deviceResponse [NUMBER_OF_DEVICES],
	input logic [NUMBER_OF_DEVICES-1:0] busRequest,
	input logic [NUMBER_OF_DEVICES-1:0] grant,
	input logic busDone,
	input cachePkg::ramRequest_t ramRequest,
	input cachePkg::lineState_t states0 [2**INDEX_WIDTH],
	input logic [ADDRESS_WIDTH-INDEX_WIDTH-1:0] tags0 [2**INDEX_WIDTH],
	input cachePkg::lineState_t states1 [2**INDEX_WIDTH],
	input logic [ADDRESS_WIDTH-INDEX_WIDTH-1:0] tags1 [2**INDEX_WIDTH]
);
	import cachePkg::*;

	int failureCount = 0;
	logic [NUMBER_OF_DEVICES-1:0] held, complete, waiting, othersIdle, lastReadValid;
	address_t lastReadAddress [NUMBER_OF_DEVICES];
	logic [1:0] resetHistory;
	logic controlsLow, doubleOwner;

	always_comb begin
		for (int i = 0; i < NUMBER_OF_DEVICES; i++) begin
			held[i] = deviceRequest[i].readEnabled || deviceRequest[i].writeEnabled;
			complete[i] = deviceResponse[i].functionComplete;
		end
	end

	assign controlsLow = !(|complete) && !(|busRequest) && !(|grant) && !busDone &&
		!ramRequest.readEnabled && !ramRequest.writeEnabled;

	// Same address owned Modified by both caches.
	always_comb begin
		doubleOwner = 1'b0;
		for (int j = 0; j < 2**INDEX_WIDTH; j++)
			if ((states0[j] == Modified) && (states1[j] == Modified) && (tags0[j] == tags1[j]))
				doubleOwner = 1'b1;
	end

	// A line stays readable until another device completes a write.
	always_ff @(posedge clock) begin
		resetHistory <= {resetHistory[0], !rstN};
		if (!rstN) begin
			waiting <= '0;
			othersIdle <= '0;
			lastReadValid <= '0;
		end else begin
			for (int i = 0; i < NUMBER_OF_DEVICES; i++) begin
				waiting[i] <= held[i] && !complete[i];
				othersIdle[i] <= (held & ~(NUMBER_OF_DEVICES'(1) << i)) == '0;
				if (complete[i] && deviceRequest[i].readEnabled) begin
					lastReadValid[i] <= 1'b1;
					lastReadAddress[i] <= deviceRequest[i].address;
				end else if (complete[i]) begin
					lastReadValid[i] <= 1'b0;
				end
				for (int j = 0; j < NUMBER_OF_DEVICES; j++)
					if ((j != i) && complete[j] && deviceRequest[j].writeEnabled)
						lastReadValid[i] <= 1'b0;
			end
		end
	end

	assert property (@(posedge clock) (resetHistory[0] || resetHistory[1]) |-> controlsLow)
	else begin
		failureCount++;
		$error("Control output active during or just after reset");
	end

	assert property (@(posedge clock) disable iff (!rstN) $onehot0(grant))
	else begin
		failureCount++;
		$error("Bus grant is not one-hot");
	end

	assert property (@(posedge clock) disable iff (!rstN) !doubleOwner)
	else begin
		failureCount++;
		$error("Two caches hold the same address Modified");
	end

	for (genvar i = 0; i < NUMBER_OF_DEVICES; i++) begin : gDevice
		assert property (@(posedge clock) disable iff (!rstN) complete[i] |=> !complete[i])
		else begin
			failureCount++;
			$error("Completion pulse longer than one cycle");
		end

		assert property (@(posedge clock) disable iff (!rstN) complete[i] |-> held[i])
		else begin
			failureCount++;
			$error("Completion without a pending request");
		end

		// Repeat read with the other devices quiet must hit.
		assert property (@(posedge clock) disable iff (!rstN)
			deviceRequest[i].readEnabled && !waiting[i] && othersIdle[i] && lastReadValid[i] &&
			(deviceRequest[i].address == lastReadAddress[i]) |=> complete[i])
		else begin
			failureCount++;
			$error("Repeat read did not complete one cycle after the request");
		end
	end

endmodule

//--- tests/MemoryTest.sv
`timescale 1ns/1ps

module MemoryTest;
	import cachePkg::*;

	localparam int DEVICES = 2;
	localparam int INDEX_WIDTH = 3;
	localparam int RAM_DELAY = 3;
	localparam int DIRECTED_OPERATIONS = 20;
	localparam int RANDOM_OPERATIONS = 300;
	localparam int OPERATIONS = DIRECTED_OPERATIONS + RANDOM_OPERATIONS;
	localparam int TIMEOUT_CYCLES = OPERATIONS * (4 * RAM_DELAY + 10) + 100;

	logic clock = 1'b0;
	logic rstN;
	deviceRequest_t deviceRequest [DEVICES];
	deviceResponse_t deviceResponse [DEVICES];

	data_t referenceMemory [2**ADDRESS_WIDTH_DEFAULT];
	logic [31:0] lfsrState = 32'he24ddb95;

	MemorySystem #(
		.NUMBER_OF_DEVICES(DEVICES),
		.INDEX_WIDTH(INDEX_WIDTH),
		.RAM_DELAY(RAM_DELAY)
	) uut (
		.clock(clock),
		.rstN(rstN),
		.deviceRequest(deviceRequest),
		.deviceResponse(deviceResponse)
	);

	bind MemorySystem memorySystem_props #(
		.NUMBER_OF_DEVICES(NUMBER_OF_DEVICES),
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.INDEX_WIDTH(INDEX_WIDTH)
	) props (
		.clock(clock),
		.rstN(rstN),
		.deviceRequest(deviceRequest),
		.deviceResponse(deviceResponse),
		.busRequest(cacheSystem.busRequest),
		.grant(cacheSystem.grant),
		.busDone(cacheSystem.done),
		.ramRequest(ramRequest),
		.states0(cacheSystem.gCache[0].cache.stateArray),
		.tags0(cacheSystem.gCache[0].cache.tagArray),
		.states1(cacheSystem.gCache[1].cache.stateArray),
		.tags1(cacheSystem.gCache[1].cache.tagArray)
	);

	always #50 clock = ~clock;

	// Taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsrNext(input logic [31:0] value);
		return {value[30:0], value[31] ^ value[21] ^ value[1] ^ value[0]};
	endfunction

	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrNext(lfsrState);
			bits = {bits[30:0], lfsrState[31]};
		end
		return bits;
	endfunction

	task automatic drive(input int device, input logic write, input address_t address,
			input data_t data);
		deviceRequest[device].address = address;
		deviceRequest[device].dataOut = data;
		deviceRequest[device].readEnabled = !write;
		deviceRequest[device].writeEnabled = write;
	endtask

	task automatic idleDevice(input int device);
		deviceRequest[device] = '0;
	endtask

	// Called on a falling edge, returns on a falling edge.
	task automatic access(input int device, input logic write, input address_t address,
			input data_t data);
		drive(device, write, address, data);
		do
			@(negedge clock);
		while (!deviceResponse[device].functionComplete);
		@(negedge clock);
		idleDevice(device);
	endtask

	task automatic readUnwritten();
		access(0, 1'b0, 8'h40, '0);
	endtask

	task automatic writeThenRead();
		access(0, 1'b1, 8'h05, 16'h1234);
		access(0, 1'b0, 8'h05, '0);
		access(0, 1'b0, 8'h05, '0);
	endtask

	task automatic shareModifiedLine();
		access(0, 1'b1, 8'h21, 16'hbeef);
		access(1, 1'b0, 8'h21, '0);
	endtask

	task automatic alternateWrites();
		for (int i = 0; i < 4; i++)
			access(i % 2, 1'b1, 8'h33, data_t'(16'h5a00 + i));
		access(0, 1'b0, 8'h33, '0);
		access(1, 1'b0, 8'h33, '0);
	endtask

	// All four addresses map to index 2.
	task automatic evictSameIndex();
		for (int i = 0; i < 4; i++)
			access(1, 1'b1, address_t'(8'h0a + 8 * i), data_t'(16'hc000 + i));
		for (int i = 0; i < 4; i++)
			access(1, 1'b0, address_t'(8'h0a + 8 * i), '0);
	endtask

	task automatic randomTraffic(input int count);
		int remaining;
		logic [DEVICES-1:0] busy, finished, issued;
		logic isWrite, clash;
		address_t address;
		data_t data;
		remaining = count;
		busy = '0;
		finished = '0;
		while ((remaining > 0) || (busy != '0)) begin
			issued = '0;
			for (int d = 0; d < DEVICES; d++) begin
				if (finished[d]) begin
					idleDevice(d);
					busy[d] = 1'b0;
				end
			end
			for (int d = 0; d < DEVICES; d++) begin
				if (!busy[d] && (remaining > 0)) begin
					isWrite = 1'(randomBits(1));
					address = address_t'(randomBits(5));
					data = data_t'(randomBits(16));
					clash = 1'b0;
					// No two devices start on one address in the same cycle.
					for (int e = 0; e < d; e++)
						if (issued[e] && (deviceRequest[e].address == address))
							clash = 1'b1;
					if (!clash) begin
						drive(d, isWrite, address, data);
						busy[d] = 1'b1;
						issued[d] = 1'b1;
						remaining--;
					end
				end
			end
			for (int d = 0; d < DEVICES; d++)
				finished[d] = busy[d] && deviceResponse[d].functionComplete;
			@(negedge clock);
		end
	endtask

	// Lower device first when completions coincide.
	always @(negedge clock) begin
		if (rstN) begin
			for (int d = 0; d < DEVICES; d++) begin
				if (deviceResponse[d].functionComplete && deviceRequest[d].writeEnabled) begin
					referenceMemory[deviceRequest[d].address] = deviceRequest[d].dataOut;
				end else if (deviceResponse[d].functionComplete) begin
					assert (deviceResponse[d].dataIn == referenceMemory[deviceRequest[d].address])
					else begin
						$display("MISMATCH at %0t: device %0d address %0h read %0h, expected %0h",
							$time, d, deviceRequest[d].address, deviceResponse[d].dataIn,
							referenceMemory[deviceRequest[d].address]);
						$display("Checks failed");
						$fatal(1, "read data differs from the reference memory");
					end
				end
			end
		end
	end

	always @(negedge clock) begin
		if (uut.props.failureCount != 0) begin
			$display("A protocol assertion on the memory system failed at %0t", $time);
			$display("Checks failed");
			$fatal(1, "protocol assertion failed");
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rstN = 1'b0;
		for (int d = 0; d < DEVICES; d++)
			deviceRequest[d] = '0;
		for (int a = 0; a < 2**ADDRESS_WIDTH_DEFAULT; a++)
			referenceMemory[a] = '0;
		repeat (3) @(negedge clock);
		rstN = 1'b1;
		readUnwritten();
		writeThenRead();
		shareModifiedLine();
		alternateWrites();
		evictSameIndex();
		randomTraffic(RANDOM_OPERATIONS);
		repeat (2) @(negedge clock);
		if (uut.props.failureCount == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1, "protocol assertion failed");
		end
	end

endmodule

//--- all.f
hw/cachePkg.sv
hw/BusArbiter.sv
hw/Ram.sv
hw/MsiCache.sv
hw/MsiCacheSystem.sv
hw/MemorySystem.sv
tests/memorySystem_props.sv
tests/MemoryTest.sv

//--- Bender.yml
package:
  name: msi_memory_system

sources:
  - files:
      - hw/cachePkg.sv
      - hw/BusArbiter.sv
      - hw/Ram.sv
      - hw/MsiCache.sv
      - hw/MsiCacheSystem.sv
      - hw/MemorySystem.sv
  - target: test
    files:
      - tests/memorySystem_props.sv
      - tests/MemoryTest.sv

# Simulation top is MemoryTest; design top is MemorySystem.
